// ==== rtl/rs_types_pkg.sv ====
// widths and entry state shared by every reservation station block
// tag zero is reserved to mean "operand present", so producers number tags from 1

package rs_types_pkg;

   //////////////////////////////////////////////////////////////////////
   // widths with a meaning
   //////////////////////////////////////////////////////////////////////

   // producer tag naming the instruction that will write a value
   typedef logic [7:0]  rs_tag_t;

   // operand or result value
   typedef logic [63:0] rs_value_t;

   // architectural destination register
   typedef logic [4:0]  rs_reg_t;

   // no wait on this operand
   localparam rs_tag_t RS_TAG_NULL = 8'd0;

   //////////////////////////////////////////////////////////////////////
   // entry state
   //////////////////////////////////////////////////////////////////////

   // bit 0 marks operand a waiting and bit 1 operand b
   typedef enum logic [2:0] {
      RS_EMPTY        = 3'b000,
      RS_WAITING_A    = 3'b001,
      RS_WAITING_B    = 3'b010,
      RS_WAITING_BOTH = 3'b011,
      RS_READY        = 3'b100
   } rs_status_e;

endpackage

// ==== rtl/rs_bus_pkg.sv ====
// bundles that cross the reservation station boundary
// a cdb broadcast with valid low never matches any tag

package rs_bus_pkg;

   //////////////////////////////////////////////////////////////////////
   // dispatch side
   //////////////////////////////////////////////////////////////////////

   // one instruction from the dispatch stage
   typedef struct packed {
      logic                    valid;
      rs_types_pkg::rs_reg_t   dest_reg;
      rs_types_pkg::rs_value_t rega_value;
      rs_types_pkg::rs_value_t regb_value;
      rs_types_pkg::rs_tag_t   taga;
      rs_types_pkg::rs_tag_t   tagb;
   } rs_dispatch_t;

   //////////////////////////////////////////////////////////////////////
   // result broadcast
   //////////////////////////////////////////////////////////////////////

   // common data bus carrying one result per cycle
   typedef struct packed {
      logic                    valid;
      rs_types_pkg::rs_tag_t   tag;
      rs_types_pkg::rs_value_t value;
   } rs_cdb_t;

   //////////////////////////////////////////////////////////////////////
   // execute side
   //////////////////////////////////////////////////////////////////////

   // one issued instruction with both operands present
   typedef struct packed {
      logic                    valid;
      rs_types_pkg::rs_reg_t   dest_reg;
      rs_types_pkg::rs_value_t rega_value;
      rs_types_pkg::rs_value_t regb_value;
   } rs_issue_t;

endpackage

// ==== rtl/rs_entry.sv ====
// single reservation station entry
// fill must only hit an empty entry and grant only a ready one
// when both cdbs carry the waited tag, cdb 0 wins

`timescale 1ns/1ps

module rs_entry (
   input  logic                     clock,
   input  logic                     reset,
   input  logic                     fill,
   input  logic                     grant,
   input  rs_bus_pkg::rs_dispatch_t dispatch_in,
   input  rs_bus_pkg::rs_cdb_t      cdb [2],
   output rs_types_pkg::rs_status_e status,
   output rs_types_pkg::rs_reg_t    dest_reg,
   output rs_types_pkg::rs_value_t  rega_value,
   output rs_types_pkg::rs_value_t  regb_value
);

   // stored waiting tags
   rs_types_pkg::rs_tag_t    taga;
   rs_types_pkg::rs_tag_t    tagb;

   // lane operands on fill and stored operands otherwise
   rs_types_pkg::rs_tag_t    src_taga;
   rs_types_pkg::rs_tag_t    src_tagb;
   rs_types_pkg::rs_value_t  src_rega;
   rs_types_pkg::rs_value_t  src_regb;

   rs_types_pkg::rs_tag_t    next_taga;
   rs_types_pkg::rs_tag_t    next_tagb;
   rs_types_pkg::rs_value_t  next_rega;
   rs_types_pkg::rs_value_t  next_regb;
   rs_types_pkg::rs_status_e next_status;

   // a null tag never matches, nor does an idle bus
   function automatic logic cdb_hit(input rs_types_pkg::rs_tag_t tag,
                                    input rs_bus_pkg::rs_cdb_t   bus);
      return bus.valid && (tag != rs_types_pkg::RS_TAG_NULL) && (bus.tag == tag);
   endfunction

   //////////////////////////////////////////////////////////////////////
   // wake-up and next state
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      if (fill)
      begin
         src_taga = dispatch_in.taga;
         src_tagb = dispatch_in.tagb;
         src_rega = dispatch_in.rega_value;
         src_regb = dispatch_in.regb_value;
      end
      else
      begin
         src_taga = taga;
         src_tagb = tagb;
         src_rega = rega_value;
         src_regb = regb_value;
      end

      // operand a wake-up also covers bypass at fill
      next_taga = src_taga;
      next_rega = src_rega;
      if (cdb_hit(src_taga, cdb[0]))
      begin
         next_taga = rs_types_pkg::RS_TAG_NULL;
         next_rega = cdb[0].value;
      end
      else if (cdb_hit(src_taga, cdb[1]))
      begin
         next_taga = rs_types_pkg::RS_TAG_NULL;
         next_rega = cdb[1].value;
      end

      // operand b
      next_tagb = src_tagb;
      next_regb = src_regb;
      if (cdb_hit(src_tagb, cdb[0]))
      begin
         next_tagb = rs_types_pkg::RS_TAG_NULL;
         next_regb = cdb[0].value;
      end
      else if (cdb_hit(src_tagb, cdb[1]))
      begin
         next_tagb = rs_types_pkg::RS_TAG_NULL;
         next_regb = cdb[1].value;
      end

      case ({next_taga != rs_types_pkg::RS_TAG_NULL, next_tagb != rs_types_pkg::RS_TAG_NULL})
         2'b00:   next_status = rs_types_pkg::RS_READY;
         2'b01:   next_status = rs_types_pkg::RS_WAITING_B;
         2'b10:   next_status = rs_types_pkg::RS_WAITING_A;
         default: next_status = rs_types_pkg::RS_WAITING_BOTH;
      endcase

      // idle entries stay empty, issued ones go back to empty
      if (grant || (!fill && status == rs_types_pkg::RS_EMPTY))
         next_status = rs_types_pkg::RS_EMPTY;
   end

   //////////////////////////////////////////////////////////////////////
   // registers
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         status <= rs_types_pkg::RS_EMPTY;
         taga   <= rs_types_pkg::RS_TAG_NULL;
         tagb   <= rs_types_pkg::RS_TAG_NULL;
      end
      else
      begin
         status <= next_status;
         taga   <= next_taga;
         tagb   <= next_tagb;
      end
   end

   // payload
   always_ff @(posedge clock)
   begin
      if (fill)
         dest_reg <= dispatch_in.dest_reg;
      rega_value <= next_rega;
      regb_value <= next_regb;
   end

   // allocator must only pick empty entries
   a_fill_empty: assert property (@(posedge clock) disable iff (reset)
      fill |-> status == rs_types_pkg::RS_EMPTY)
      else $error("rs_entry: fill into an occupied entry");

   // issue selector must only grant ready entries
   a_grant_ready: assert property (@(posedge clock) disable iff (reset)
      grant |-> status == rs_types_pkg::RS_READY)
      else $error("rs_entry: grant to an entry that is not ready");

   a_ready_tags: assert property (@(posedge clock) disable iff (reset)
      status == rs_types_pkg::RS_READY |->
         (taga == rs_types_pkg::RS_TAG_NULL) && (tagb == rs_types_pkg::RS_TAG_NULL))
      else $error("rs_entry: ready entry still holds a waiting tag");

endmodule

// ==== rtl/rs_alloc.sv ====
// picks the two lowest empty entries for the two dispatch lanes
// accept depends only on the registered status, never on dispatch valid
// lane 1 gets the second free entry even when lane 0 is idle

`timescale 1ns/1ps

module rs_alloc #(
   parameter int NUM_ENTRIES = 8
) (
   input  rs_types_pkg::rs_status_e status [NUM_ENTRIES],
   input  logic [1:0]               dispatch_valid,
   output logic [NUM_ENTRIES-1:0]   fill,
   output logic [NUM_ENTRIES-1:0]   lane_sel,
   output logic [1:0]               accept
);

   localparam int IDX_W = $clog2(NUM_ENTRIES);

   logic [NUM_ENTRIES-1:0] free;
   logic                   first_found;
   logic [IDX_W-1:0]       first_idx;
   logic                   second_found;
   logic [IDX_W-1:0]       second_idx;

   always_comb
   begin
      for (int i = 0; i < NUM_ENTRIES; i++)
         free[i] = (status[i] == rs_types_pkg::RS_EMPTY);
   end

   // lowest free entry, then the next free one above it
   always_comb
   begin
      first_found  = 1'b0;
      first_idx    = '0;
      second_found = 1'b0;
      second_idx   = '0;
      for (int i = 0; i < NUM_ENTRIES; i++)
      begin
         if (free[i] && !first_found)
         begin
            first_found = 1'b1;
            first_idx   = IDX_W'(i);
         end
         else if (free[i] && !second_found)
         begin
            second_found = 1'b1;
            second_idx   = IDX_W'(i);
         end
      end
   end

   // route lanes to entries, fill only for taken lanes
   always_comb
   begin
      for (int i = 0; i < NUM_ENTRIES; i++)
      begin
         lane_sel[i] = second_found && (second_idx == IDX_W'(i));
         fill[i]     = (dispatch_valid[0] && first_found && (first_idx == IDX_W'(i)))
                    || (dispatch_valid[1] && lane_sel[i]);
      end
   end

   assign accept = {second_found, first_found};

   a_fill_count: assert final ($countones(fill) <= 2)
      else $error("rs_alloc: more than two entries filled in one cycle");

endmodule

// ==== rtl/rs_issue_select.sv ====
// picks the two lowest ready entries and presents them as issue slots
// slots are combinational from entry state, issue_hold blanks both
// slot contents are only meaningful while the slot valid bit is high

`timescale 1ns/1ps

module rs_issue_select #(
   parameter int NUM_ENTRIES = 8
) (
   input  rs_types_pkg::rs_status_e status     [NUM_ENTRIES],
   input  rs_types_pkg::rs_reg_t    dest_reg   [NUM_ENTRIES],
   input  rs_types_pkg::rs_value_t  rega_value [NUM_ENTRIES],
   input  rs_types_pkg::rs_value_t  regb_value [NUM_ENTRIES],
   input  logic                     issue_hold,
   output logic [NUM_ENTRIES-1:0]   grant,
   output rs_bus_pkg::rs_issue_t    issue      [2]
);

   localparam int IDX_W = $clog2(NUM_ENTRIES);

   logic [NUM_ENTRIES-1:0] ready;
   logic                   slot_found [2];
   logic [IDX_W-1:0]       slot_idx   [2];

   always_comb
   begin
      for (int i = 0; i < NUM_ENTRIES; i++)
         ready[i] = (status[i] == rs_types_pkg::RS_READY);
   end

   //////////////////////////////////////////////////////////////////////
   // two lowest-index searches
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      slot_found[0] = 1'b0;
      slot_idx[0]   = '0;
      slot_found[1] = 1'b0;
      slot_idx[1]   = '0;
      for (int i = 0; i < NUM_ENTRIES; i++)
      begin
         if (ready[i] && !slot_found[0])
         begin
            slot_found[0] = 1'b1;
            slot_idx[0]   = IDX_W'(i);
         end
         else if (ready[i] && !slot_found[1])
         begin
            slot_found[1] = 1'b1;
            slot_idx[1]   = IDX_W'(i);
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // slot muxes and grants
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      for (int k = 0; k < 2; k++)
      begin
         issue[k].valid      = slot_found[k] && !issue_hold;
         issue[k].dest_reg   = dest_reg[slot_idx[k]];
         issue[k].rega_value = rega_value[slot_idx[k]];
         issue[k].regb_value = regb_value[slot_idx[k]];
      end
   end

   // an entry leaves only through a valid slot
   always_comb
   begin
      for (int i = 0; i < NUM_ENTRIES; i++)
         grant[i] = (issue[0].valid && (slot_idx[0] == IDX_W'(i)))
                 || (issue[1].valid && (slot_idx[1] == IDX_W'(i)));
   end

   // one grant per valid slot, so the slots hit distinct entries
   a_grant_distinct: assert final
      ($countones(grant) == (32'(issue[0].valid) + 32'(issue[1].valid)))
      else $error("rs_issue_select: both slots point at the same entry");

endmodule

// ==== rtl/rs_table.sv ====
// dual-dispatch, dual-issue reservation station table
// accept is combinational from registered status, hold a refused lane and retry
// no flush and no age order, issue goes lowest index first

`timescale 1ns/1ps

module rs_table #(
   parameter int NUM_ENTRIES = 8
) (
   input  logic                     clock,
   input  logic                     reset,
   input  rs_bus_pkg::rs_dispatch_t dispatch [2],
   input  rs_bus_pkg::rs_cdb_t      cdb      [2],
   input  logic                     issue_hold,
   output logic [1:0]               accept,
   output rs_bus_pkg::rs_issue_t    issue    [2],
   output logic                     table_full
);

   // per-entry state gathered for the allocator and the selector
   rs_types_pkg::rs_status_e status     [NUM_ENTRIES];
   rs_types_pkg::rs_reg_t    dest_reg   [NUM_ENTRIES];
   rs_types_pkg::rs_value_t  rega_value [NUM_ENTRIES];
   rs_types_pkg::rs_value_t  regb_value [NUM_ENTRIES];

   logic [NUM_ENTRIES-1:0]   fill;
   logic [NUM_ENTRIES-1:0]   lane_sel;
   logic [NUM_ENTRIES-1:0]   grant;
   logic [1:0]               dispatch_valid;

   // two lanes need at least two entries
   if (NUM_ENTRIES < 2)
   begin : g_size_check
      $error("rs_table: NUM_ENTRIES must be at least 2");
   end

   assign dispatch_valid = {dispatch[1].valid, dispatch[0].valid};

   //////////////////////////////////////////////////////////////////////
   // entry array
   //////////////////////////////////////////////////////////////////////

   for (genvar i = 0; i < NUM_ENTRIES; i++)
   begin : g_entry
      rs_bus_pkg::rs_dispatch_t lane;

      // lane chosen for this entry by the allocator
      assign lane = lane_sel[i] ? dispatch[1] : dispatch[0];

      rs_entry u_entry (
         .clock       (clock),
         .reset       (reset),
         .fill        (fill[i]),
         .grant       (grant[i]),
         .dispatch_in (lane),
         .cdb         (cdb),
         .status      (status[i]),
         .dest_reg    (dest_reg[i]),
         .rega_value  (rega_value[i]),
         .regb_value  (regb_value[i])
      );
   end

   //////////////////////////////////////////////////////////////////////
   // allocation and issue
   //////////////////////////////////////////////////////////////////////

   rs_alloc #(
      .NUM_ENTRIES (NUM_ENTRIES)
   ) u_alloc (
      .status         (status),
      .dispatch_valid (dispatch_valid),
      .fill           (fill),
      .lane_sel       (lane_sel),
      .accept         (accept)
   );

   rs_issue_select #(
      .NUM_ENTRIES (NUM_ENTRIES)
   ) u_issue_select (
      .status     (status),
      .dest_reg   (dest_reg),
      .rega_value (rega_value),
      .regb_value (regb_value),
      .issue_hold (issue_hold),
      .grant      (grant),
      .issue      (issue)
   );

   // full when no entry is empty
   always_comb
   begin
      table_full = 1'b1;
      for (int i = 0; i < NUM_ENTRIES; i++)
      begin
         if (status[i] == rs_types_pkg::RS_EMPTY)
            table_full = 1'b0;
      end
   end

endmodule

// ==== testbench/rs_table_tb_cases.svh ====
// scenario table, one row per clock cycle
// columns are scenario, lane 0, lane 1, cdb 0, cdb 1, issue_hold, check
// lane and bus values are drawn at random when a row is applied

   localparam lane_row_t IDLE_LANE = '0;
   localparam bus_row_t  IDLE_BUS  = '0;

   function automatic lane_row_t ready_lane(input rs_types_pkg::rs_reg_t dest_reg);
      return '{1'b1, dest_reg, 8'd0, 8'd0};
   endfunction

   function automatic lane_row_t waiting_lane(input rs_types_pkg::rs_reg_t dest_reg,
                                              input rs_types_pkg::rs_tag_t taga,
                                              input rs_types_pkg::rs_tag_t tagb);
      return '{1'b1, dest_reg, taga, tagb};
   endfunction

   function automatic bus_row_t broadcast(input rs_types_pkg::rs_tag_t tag);
      return '{1'b1, tag};
   endfunction

   task automatic add_row(input int group, input lane_row_t lane0, input lane_row_t lane1,
                          input bus_row_t cdb0, input bus_row_t cdb1,
                          input logic hold, input logic check);
      cases.push_back('{3'(group), lane0, lane1, cdb0, cdb1, hold, check});
   endtask

   task automatic load_cases();
      // reset state
      add_row(1, IDLE_LANE, IDLE_LANE, IDLE_BUS, IDLE_BUS, 1'b0, 1'b1);
      // two ready instructions, next cycle issue, then empty
      add_row(2, ready_lane(5'd1), ready_lane(5'd2), IDLE_BUS, IDLE_BUS, 1'b0, 1'b1);
      add_row(2, IDLE_LANE, IDLE_LANE, IDLE_BUS, IDLE_BUS, 1'b0, 1'b1);
      add_row(2, IDLE_LANE, IDLE_LANE, IDLE_BUS, IDLE_BUS, 1'b0, 1'b1);
      // wake-up by cdb 0, then by cdb 1, idle bus must not match
      add_row(3, waiting_lane(5'd3, 8'h21, 8'h00), waiting_lane(5'd4, 8'h00, 8'h22),
              IDLE_BUS, IDLE_BUS, 1'b0, 1'b1);
      add_row(3, IDLE_LANE, IDLE_LANE, IDLE_BUS, '{1'b0, 8'h22}, 1'b0, 1'b1);
      add_row(3, IDLE_LANE, IDLE_LANE, broadcast(8'h21), IDLE_BUS, 1'b0, 1'b1);
      add_row(3, IDLE_LANE, IDLE_LANE, IDLE_BUS, IDLE_BUS, 1'b0, 1'b1);
      add_row(3, IDLE_LANE, IDLE_LANE, IDLE_BUS, broadcast(8'h22), 1'b0, 1'b1);
      add_row(3, IDLE_LANE, IDLE_LANE, IDLE_BUS, IDLE_BUS, 1'b0, 1'b1);
      add_row(3, IDLE_LANE, IDLE_LANE, IDLE_BUS, IDLE_BUS, 1'b0, 1'b1);
      // bypass at fill from both buses
      add_row(4, waiting_lane(5'd7, 8'h31, 8'h32), waiting_lane(5'd8, 8'h31, 8'h00),
              broadcast(8'h31), broadcast(8'h32), 1'b0, 1'b1);
      add_row(4, IDLE_LANE, IDLE_LANE, IDLE_BUS, IDLE_BUS, 1'b0, 1'b1);
      add_row(4, IDLE_LANE, IDLE_LANE, IDLE_BUS, IDLE_BUS, 1'b0, 1'b1);
      // fill all eight under hold, refused lanes at full, then drain in order
      add_row(5, ready_lane(5'd10), ready_lane(5'd11), IDLE_BUS, IDLE_BUS, 1'b1, 1'b1);
      add_row(5, ready_lane(5'd12), ready_lane(5'd13), IDLE_BUS, IDLE_BUS, 1'b1, 1'b1);
      add_row(5, ready_lane(5'd14), ready_lane(5'd15), IDLE_BUS, IDLE_BUS, 1'b1, 1'b1);
      add_row(5, ready_lane(5'd16), ready_lane(5'd17), IDLE_BUS, IDLE_BUS, 1'b1, 1'b1);
      add_row(5, ready_lane(5'd20), ready_lane(5'd21), IDLE_BUS, IDLE_BUS, 1'b1, 1'b1);
      add_row(5, IDLE_LANE, IDLE_LANE, IDLE_BUS, IDLE_BUS, 1'b0, 1'b1);
      add_row(5, IDLE_LANE, IDLE_LANE, IDLE_BUS, IDLE_BUS, 1'b0, 1'b1);
      add_row(5, IDLE_LANE, IDLE_LANE, IDLE_BUS, IDLE_BUS, 1'b0, 1'b1);
      add_row(5, IDLE_LANE, IDLE_LANE, IDLE_BUS, IDLE_BUS, 1'b0, 1'b1);
      add_row(5, IDLE_LANE, IDLE_LANE, IDLE_BUS, IDLE_BUS, 1'b0, 1'b1);
   endtask

// ==== testbench/rs_table_tb.sv ====
// self-checking testbench for rs_table with eight entries
// expected outputs come from a behavioral model of the table rules
// lane and cdb values are random, tags and lane use come from the case table

`timescale 1ns/1ps

module rs_table_tb;

   localparam int  NUM_ENTRIES = 8;
   localparam time PERIOD      = 10ns;

   typedef struct packed {
      logic                  valid;
      rs_types_pkg::rs_reg_t dest_reg;
      rs_types_pkg::rs_tag_t taga;
      rs_types_pkg::rs_tag_t tagb;
   } lane_row_t;

   typedef struct packed {
      logic                  valid;
      rs_types_pkg::rs_tag_t tag;
   } bus_row_t;

   // one clock cycle of stimulus
   typedef struct packed {
      logic [2:0] group;
      lane_row_t  lane0;
      lane_row_t  lane1;
      bus_row_t   cdb0;
      bus_row_t   cdb1;
      logic       hold;
      logic       check;
   } case_row_t;

   typedef struct packed {
      logic                    busy;
      rs_types_pkg::rs_reg_t   dest_reg;
      rs_types_pkg::rs_tag_t   taga;
      rs_types_pkg::rs_tag_t   tagb;
      rs_types_pkg::rs_value_t rega_value;
      rs_types_pkg::rs_value_t regb_value;
   } model_entry_t;

   logic                     clock;
   logic                     reset;
   rs_bus_pkg::rs_dispatch_t dispatch [2];
   rs_bus_pkg::rs_cdb_t      cdb      [2];
   logic                     issue_hold;
   logic [1:0]               accept;
   rs_bus_pkg::rs_issue_t    issue    [2];
   logic                     table_full;

   case_row_t    cases [$];
   model_entry_t model [NUM_ENTRIES];

   // model predictions for the current cycle
   logic [1:0]   exp_accept;
   logic         exp_full;
   logic         exp_valid [2];
   int           exp_idx   [2];
   int           free_idx  [2];
   int           free_count;

   int           group_errors;
   int           tests_run;
   int           tests_failed;

   `include "rs_table_tb_cases.svh"

   rs_table #(
      .NUM_ENTRIES (NUM_ENTRIES)
   ) u_dut (
      .clock      (clock),
      .reset      (reset),
      .dispatch   (dispatch),
      .cdb        (cdb),
      .issue_hold (issue_hold),
      .accept     (accept),
      .issue      (issue),
      .table_full (table_full)
   );

   initial
   begin
      clock = 1'b0;
      forever #(PERIOD / 2) clock = ~clock;
   end

   //////////////////////////////////////////////////////////////////////
   // stimulus and model helpers
   //////////////////////////////////////////////////////////////////////

   function automatic rs_bus_pkg::rs_dispatch_t make_dispatch(input lane_row_t lane);
      rs_bus_pkg::rs_dispatch_t d;
      d.valid      = lane.valid;
      d.dest_reg   = lane.dest_reg;
      d.taga       = lane.taga;
      d.tagb       = lane.tagb;
      d.rega_value = {$urandom, $urandom};
      d.regb_value = {$urandom, $urandom};
      return d;
   endfunction

   function automatic rs_bus_pkg::rs_cdb_t make_cdb(input bus_row_t bus);
      rs_bus_pkg::rs_cdb_t c;
      c.valid = bus.valid;
      c.tag   = bus.tag;
      c.value = {$urandom, $urandom};
      return c;
   endfunction

   // capture a broadcast result with cdb 0 taking priority
   task automatic wake_operand(inout rs_types_pkg::rs_tag_t tag,
                               inout rs_types_pkg::rs_value_t value);
      for (int b = 0; b < 2; b++)
      begin
         if (cdb[b].valid && tag != 8'd0 && cdb[b].tag == tag)
         begin
            value = cdb[b].value;
            tag   = 8'd0;
         end
      end
   endtask

   task automatic load_entry(input int idx, input rs_bus_pkg::rs_dispatch_t d);
      model[idx] = '{1'b1, d.dest_reg, d.taga, d.tagb, d.rega_value, d.regb_value};
      wake_operand(model[idx].taga, model[idx].rega_value);
      wake_operand(model[idx].tagb, model[idx].regb_value);
   endtask

   task automatic predict_outputs();
      int ready_count;
      free_count  = 0;
      ready_count = 0;
      exp_valid   = '{1'b0, 1'b0};
      for (int i = 0; i < NUM_ENTRIES; i++)
      begin
         if (!model[i].busy)
         begin
            if (free_count < 2)
               free_idx[free_count] = i;
            free_count++;
         end
         else if (model[i].taga == 8'd0 && model[i].tagb == 8'd0 && ready_count < 2)
         begin
            exp_valid[ready_count] = !issue_hold;
            exp_idx[ready_count]   = i;
            ready_count++;
         end
      end
      exp_accept = {free_count >= 2, free_count >= 1};
      exp_full   = (free_count == 0);
   endtask

   // state after the coming edge
   task automatic advance_model();
      for (int k = 0; k < 2; k++)
      begin
         if (exp_valid[k])
            model[exp_idx[k]].busy = 1'b0;
      end
      for (int i = 0; i < NUM_ENTRIES; i++)
      begin
         if (model[i].busy)
         begin
            wake_operand(model[i].taga, model[i].rega_value);
            wake_operand(model[i].tagb, model[i].regb_value);
         end
      end
      if (dispatch[0].valid && free_count >= 1)
         load_entry(free_idx[0], dispatch[0]);
      if (dispatch[1].valid && free_count >= 2)
         load_entry(free_idx[1], dispatch[1]);
   endtask

   //////////////////////////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////////////////////////

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      assert (actual === expected)
      else
      begin
         $display("FAIL %0t %s expected %0h actual %0h", $time, name, expected, actual);
         group_errors++;
      end
   endtask

   task automatic check_outputs();
      model_entry_t e;
      check_value("accept", 64'(exp_accept), 64'(accept));
      check_value("table_full", 64'(exp_full), 64'(table_full));
      for (int k = 0; k < 2; k++)
      begin
         check_value($sformatf("issue[%0d].valid", k), 64'(exp_valid[k]), 64'(issue[k].valid));
         if (exp_valid[k])
         begin
            e = model[exp_idx[k]];
            check_value($sformatf("issue[%0d].dest_reg", k), 64'(e.dest_reg),
                        64'(issue[k].dest_reg));
            check_value($sformatf("issue[%0d].rega_value", k), e.rega_value,
                        issue[k].rega_value);
            check_value($sformatf("issue[%0d].regb_value", k), e.regb_value,
                        issue[k].regb_value);
         end
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////////////////////////

   initial
   begin
      void'($urandom(32'h6a20_3418));
      reset        = 1'b1;
      issue_hold   = 1'b0;
      dispatch[0]  = '0;
      dispatch[1]  = '0;
      cdb[0]       = '0;
      cdb[1]       = '0;
      group_errors = 0;
      tests_run    = 0;
      tests_failed = 0;
      for (int i = 0; i < NUM_ENTRIES; i++)
         model[i] = '0;
      load_cases();

      repeat (2) @(posedge clock);
      #1 reset = 1'b0;

      for (int r = 0; r < cases.size(); r++)
      begin
         dispatch[0] = make_dispatch(cases[r].lane0);
         dispatch[1] = make_dispatch(cases[r].lane1);
         cdb[0]      = make_cdb(cases[r].cdb0);
         cdb[1]      = make_cdb(cases[r].cdb1);
         issue_hold  = cases[r].hold;
         // sample once the combinational outputs have settled
         #4;
         predict_outputs();
         if (cases[r].check)
            check_outputs();
         advance_model();
         if (r == cases.size() - 1 || cases[r + 1].group != cases[r].group)
         begin
            tests_run++;
            if (group_errors != 0)
               tests_failed++;
            $display("test %0d: %s, %0d errors", cases[r].group,
                     (group_errors == 0) ? "passed" : "failed", group_errors);
            group_errors = 0;
         end
         @(posedge clock);
         #1;
      end

      $display("tests run %0d, passed %0d, failed %0d",
               tests_run, tests_run - tests_failed, tests_failed);
      if (tests_failed == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

   // one cycle per row plus reset and some slack
   initial
   begin
      #1;
      #((cases.size() + 2 + 20) * PERIOD);
      $display("watchdog: the run did not finish in time and was stopped");
      $display("tests failed");
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+testbench
rtl/rs_types_pkg.sv
rtl/rs_bus_pkg.sv
rtl/rs_entry.sv
rtl/rs_alloc.sv
rtl/rs_issue_select.sv
rtl/rs_table.sv
testbench/rs_table_tb.sv

// ==== Bender.yml ====
package:
  name: rs_table

sources:
  - files:
      - rtl/rs_types_pkg.sv
      - rtl/rs_bus_pkg.sv
      - rtl/rs_entry.sv
      - rtl/rs_alloc.sv
      - rtl/rs_issue_select.sv
      - rtl/rs_table.sv

  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/rs_table_tb.sv
